/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_dsp_unit
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
rtl/dsp_pkg.sv
rtl/dsp_addsub.sv
rtl/dsp_adder.sv
rtl/dsp_shift_dp.sv
rtl/dsp_shift.sv
rtl/dsp_wbck.sv
rtl/dsp_unit.sv
testbench/tb_dsp_unit.sv

/* rtl/dsp_adder.sv */
`timescale 1ns/100ps

module dsp_adder import dsp_pkg::*; (
  input  logic                   add_req_i,
  input  logic                   add_sub_en_i,
  input  logic                   add_lane16_i,
  input  logic                   round_req_i,
  input  logic [adder_width-1:0] add_op1_i,
  input  logic [adder_width-1:0] add_op2_i,
  input  logic [adder_width-1:0] round_op1_i,
  input  logic [adder_width-1:0] round_op2_i,
  output logic [adder_width-1:0] add_res_o
);

  logic                   req;
  logic                   sub_en;
  logic                   lane16;
  logic [adder_width-1:0] op1;
  logic [adder_width-1:0] op2;
  logic [adder_width-1:0] seg_sum;
  logic [lane8_num-1:0]   seg_cin;
  logic [lane8_num-1:0]   seg_cout;

  // requester select, rounding never subtracts and is always 16-bit
  assign req    = add_req_i | round_req_i;
  assign op1    = round_req_i ? round_op1_i : add_op1_i;
  assign op2    = round_req_i ? round_op2_i : add_op2_i;
  assign sub_en = add_req_i & add_sub_en_i & ~round_req_i;
  assign lane16 = round_req_i | add_lane16_i;

  for (genvar s = 0; s < lane8_num; s++) begin : g_seg
    if (s % 2 == 1) begin : g_upper
      // upper half of a 16-bit lane takes the lower segment's carry
      assign seg_cin[s] = lane16 ? seg_cout[s-1] : sub_en;
    end else begin : g_lower
      assign seg_cin[s] = sub_en;
    end
    assign {seg_cout[s], seg_sum[s*adder_lane_width +: adder_lane_width]} =
      {1'b0, op1[s*adder_lane_width +: adder_lane_width]} +
      {1'b0, op2[s*adder_lane_width +: adder_lane_width]} +
      {{adder_lane_width{1'b0}}, seg_cin[s]};
  end

  assign add_res_o = req ? seg_sum : '0;

endmodule

/* rtl/dsp_addsub.sv */
`timescale 1ns/100ps

module dsp_addsub import dsp_pkg::*; (
  input  dsp_op_e                op_i,
  input  logic [xlen-1:0]        rs1_i,
  input  logic [xlen-1:0]        rs2_i,
  input  logic [adder_width-1:0] add_res_i,
  output logic                   add_req_o,
  output logic                   add_sub_en_o,
  output logic                   add_lane16_o,
  output logic [adder_width-1:0] add_op1_o,
  output logic [adder_width-1:0] add_op2_o,
  output logic [xlen-1:0]        wdat_o,
  output logic                   ov_o
);

  logic                   lane16;
  logic                   lane8;
  logic                   sub;
  logic                   sgn;
  logic                   halve;
  logic                   ssat;
  logic                   usat;
  logic [adder_width-1:0] op2_ext;

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////
  assign lane16 = op_i inside {op_add16, op_sub16, op_radd16, op_kadd16, op_ksub16, op_ukadd16};
  assign lane8  = op_i inside {op_add8, op_sub8, op_kadd8, op_ksub8};
  assign sub    = op_i inside {op_sub16, op_ksub16, op_sub8, op_ksub8};
  // only the unsigned saturating add zero-extends
  assign sgn    = (op_i != op_ukadd16);
  assign halve  = (op_i == op_radd16);
  assign ssat   = op_i inside {op_kadd16, op_ksub16, op_kadd8, op_ksub8};
  assign usat   = (op_i == op_ukadd16);

  assign add_req_o    = lane16 | lane8;
  assign add_sub_en_o = sub;
  assign add_lane16_o = lane16;

  //////////////////////////////////////////////////////////////////////
  // lane operands into adder segments
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    add_op1_o = '0;
    op2_ext   = '0;
    if (lane16) begin
      // a 16-bit lane spans a pair of segments
      for (int i = 0; i < lane16_num; i++) begin
        add_op1_o[i*2*adder_lane_width +: 2*adder_lane_width] =
          {{2{sgn & rs1_i[i*16+15]}}, rs1_i[i*16 +: 16]};
        op2_ext[i*2*adder_lane_width +: 2*adder_lane_width] =
          {{2{sgn & rs2_i[i*16+15]}}, rs2_i[i*16 +: 16]};
      end
    end else if (lane8) begin
      for (int i = 0; i < lane8_num; i++) begin
        add_op1_o[i*adder_lane_width +: adder_lane_width] = {sgn & rs1_i[i*8+7], rs1_i[i*8 +: 8]};
        op2_ext[i*adder_lane_width +: adder_lane_width]   = {sgn & rs2_i[i*8+7], rs2_i[i*8 +: 8]};
      end
    end
  end

  // subtract as op1 + ~op2 + 1, the adder supplies the carry-in
  assign add_op2_o = sub ? ~op2_ext : op2_ext;

  //////////////////////////////////////////////////////////////////////
  // sum post-processing
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    logic [2*adder_lane_width-1:0] s16;
    logic [adder_lane_width-1:0]   s8;
    wdat_o = '0;
    ov_o   = 1'b0;
    s16    = '0;
    s8     = '0;
    if (lane16) begin
      for (int i = 0; i < lane16_num; i++) begin
        s16 = add_res_i[i*2*adder_lane_width +: 2*adder_lane_width];
        if (halve) begin
          wdat_o[i*16 +: 16] = s16[16:1];
        end else if (ssat && (s16[16] != s16[15])) begin
          // signed overflow, clamp toward the sign of the true sum
          wdat_o[i*16 +: 16] = s16[16] ? 16'h8000 : 16'h7fff;
          ov_o               = 1'b1;
        end else if (usat && s16[16]) begin
          wdat_o[i*16 +: 16] = 16'hffff;
          ov_o               = 1'b1;
        end else begin
          wdat_o[i*16 +: 16] = s16[15:0];
        end
      end
    end else if (lane8) begin
      for (int i = 0; i < lane8_num; i++) begin
        s8 = add_res_i[i*adder_lane_width +: adder_lane_width];
        if (ssat && (s8[8] != s8[7])) begin
          wdat_o[i*8 +: 8] = s8[8] ? 8'h80 : 8'h7f;
          ov_o             = 1'b1;
        end else begin
          wdat_o[i*8 +: 8] = s8[7:0];
        end
      end
    end
  end

endmodule

/* rtl/dsp_pkg.sv */
package dsp_pkg;

  //////////////////////////////////////////////////////////////////////
  // datapath widths
  //////////////////////////////////////////////////////////////////////

  // register and write-back width
  localparam int xlen = 32;

  // simd lane counts per 32-bit word
  localparam int lane16_num = 2;
  localparam int lane8_num  = 4;

  // shift amount for 16-bit lanes, low bits of rs2
  localparam int shamt16_width = 4;

  // one adder segment is an 8-bit lane plus a guard bit
  localparam int adder_lane_width = 9;
  localparam int adder_width      = 36;

  //////////////////////////////////////////////////////////////////////
  // operation codes
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    op_add16   = 4'd0,
    op_sub16   = 4'd1,
    // signed halving add
    op_radd16  = 4'd2,
    op_kadd16  = 4'd3,
    op_ksub16  = 4'd4,
    op_ukadd16 = 4'd5,
    op_add8    = 4'd6,
    op_sub8    = 4'd7,
    op_kadd8   = 4'd8,
    op_ksub8   = 4'd9,
    op_srl16   = 4'd10,
    op_sra16   = 4'd11,
    // rounding arithmetic right
    op_sra16_u = 4'd12,
    op_sll16   = 4'd13,
    op_ksll16  = 4'd14,
    op_nop     = 4'd15
  } dsp_op_e;

endpackage

/* rtl/dsp_shift.sv */
`timescale 1ns/100ps

module dsp_shift import dsp_pkg::*; (
  input  dsp_op_e                  op_i,
  input  logic [xlen-1:0]          rs1_i,
  input  logic [xlen-1:0]          rs2_i,
  input  logic [xlen-1:0]          right_res_i,
  input  logic [xlen-1:0]          left_res_i,
  input  logic [adder_width-1:0]   add_res_i,
  output logic [xlen-1:0]          shift_op_o,
  output logic [shamt16_width-1:0] shamt_o,
  output logic                     arith_o,
  output logic                     round_req_o,
  output logic [adder_width-1:0]   round_op1_o,
  output logic [adder_width-1:0]   round_op2_o,
  output logic [xlen-1:0]          wdat_o,
  output logic                     ov_o
);

  logic                     is_shift;
  logic                     is_left;
  logic                     is_ksll;
  logic                     round_en;
  logic [shamt16_width-1:0] amt;

  //////////////////////////////////////////////////////////////////////
  // decode and shifter control
  //////////////////////////////////////////////////////////////////////
  assign amt      = rs2_i[shamt16_width-1:0];
  assign is_shift = op_i inside {op_srl16, op_sra16, op_sra16_u, op_sll16, op_ksll16};
  assign is_left  = op_i inside {op_sll16, op_ksll16};
  assign is_ksll  = (op_i == op_ksll16);
  // zero amount needs no rounding, rs1 passes through
  assign round_en = (op_i == op_sra16_u) && (amt != '0);

  assign shift_op_o = is_shift ? rs1_i : '0;
  // rounding shift stops one bit early so the adder sees the round bit
  assign shamt_o    = round_en ? amt - 1'b1 : amt;
  assign arith_o    = op_i inside {op_sra16, op_sra16_u};

  //////////////////////////////////////////////////////////////////////
  // rounding request to the shared adder
  //////////////////////////////////////////////////////////////////////
  assign round_req_o = round_en;

  always_comb begin
    round_op1_o = '0;
    round_op2_o = '0;
    if (round_en) begin
      for (int i = 0; i < lane16_num; i++) begin
        round_op1_o[i*2*adder_lane_width +: 2*adder_lane_width] =
          {{2{right_res_i[i*16+15]}}, right_res_i[i*16 +: 16]};
        // plus one per lane
        round_op2_o[i*2*adder_lane_width +: 2*adder_lane_width] = 18'd1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // result select and left saturation
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    logic [15:0] orig;
    logic [15:0] lsh;
    logic [15:0] back;
    wdat_o = '0;
    ov_o   = 1'b0;
    orig   = '0;
    lsh    = '0;
    back   = '0;
    if (is_shift) begin
      for (int i = 0; i < lane16_num; i++) begin
        orig = rs1_i[i*16 +: 16];
        lsh  = left_res_i[i*16 +: 16];
        // shifting back must recover the lane if no bits were lost
        back = $signed(lsh) >>> amt;
        if (round_en) begin
          wdat_o[i*16 +: 16] = add_res_i[i*2*adder_lane_width+1 +: 16];
        end else if (is_left) begin
          if (is_ksll && (back != orig)) begin
            wdat_o[i*16 +: 16] = orig[15] ? 16'h8000 : 16'h7fff;
            ov_o               = 1'b1;
          end else begin
            wdat_o[i*16 +: 16] = lsh;
          end
        end else begin
          wdat_o[i*16 +: 16] = right_res_i[i*16 +: 16];
        end
      end
    end
  end

endmodule

/* rtl/dsp_shift_dp.sv */
`timescale 1ns/100ps

module dsp_shift_dp import dsp_pkg::*; (
  input  logic [xlen-1:0]          op_i,
  input  logic [shamt16_width-1:0] shamt_i,
  input  logic                     arith_i,
  output logic [xlen-1:0]          right_res_o,
  output logic [xlen-1:0]          left_res_o
);

  // both lanes share one shift amount
  always_comb begin
    logic [16:0] ext;
    right_res_o = '0;
    left_res_o  = '0;
    ext         = '0;
    for (int i = 0; i < lane16_num; i++) begin
      // fill bit is the lane sign for arithmetic shifts, else zero
      ext = {arith_i & op_i[i*16+15], op_i[i*16 +: 16]};
      right_res_o[i*16 +: 16] = 16'($signed(ext) >>> shamt_i);
      // left shift wraps, saturation is handled by the caller
      left_res_o[i*16 +: 16]  = op_i[i*16 +: 16] << shamt_i;
    end
  end

endmodule

/* rtl/dsp_unit.sv */
`timescale 1ns/100ps

module dsp_unit import dsp_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  dsp_op_e         op_i,
  input  logic [xlen-1:0] rs1_i,
  input  logic [xlen-1:0] rs2_i,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  output logic            out_valid_o,
  input  logic            out_ready_i,
  input  logic            ov_clr_i,
  output logic [xlen-1:0] wbck_wdat_o,
  output logic            wbck_ov_o,
  output logic            ov_flag_o
);

  logic                     add_req;
  logic                     add_sub_en;
  logic                     add_lane16;
  logic [adder_width-1:0]   add_op1;
  logic [adder_width-1:0]   add_op2;
  logic [adder_width-1:0]   add_res;
  logic                     round_req;
  logic [adder_width-1:0]   round_op1;
  logic [adder_width-1:0]   round_op2;
  logic [xlen-1:0]          shift_op;
  logic [shamt16_width-1:0] shamt;
  logic                     arith;
  logic [xlen-1:0]          right_res;
  logic [xlen-1:0]          left_res;
  logic [xlen-1:0]          addsub_wdat;
  logic [xlen-1:0]          shift_wdat;
  logic                     addsub_ov;
  logic                     shift_ov;

  // single-cycle unit, handshake passes straight through
  assign out_valid_o = in_valid_i;
  assign in_ready_o  = out_ready_i;

  //////////////////////////////////////////////////////////////////////
  // add/subtract and shared adder
  //////////////////////////////////////////////////////////////////////
  dsp_addsub u_dsp_addsub (
    .op_i         (op_i),
    .rs1_i        (rs1_i),
    .rs2_i        (rs2_i),
    .add_res_i    (add_res),
    .add_req_o    (add_req),
    .add_sub_en_o (add_sub_en),
    .add_lane16_o (add_lane16),
    .add_op1_o    (add_op1),
    .add_op2_o    (add_op2),
    .wdat_o       (addsub_wdat),
    .ov_o         (addsub_ov)
  );

  dsp_adder u_dsp_adder (
    .add_req_i    (add_req),
    .add_sub_en_i (add_sub_en),
    .add_lane16_i (add_lane16),
    .round_req_i  (round_req),
    .add_op1_i    (add_op1),
    .add_op2_i    (add_op2),
    .round_op1_i  (round_op1),
    .round_op2_i  (round_op2),
    .add_res_o    (add_res)
  );

  //////////////////////////////////////////////////////////////////////
  // shifter
  //////////////////////////////////////////////////////////////////////
  dsp_shift_dp u_dsp_shift_dp (
    .op_i        (shift_op),
    .shamt_i     (shamt),
    .arith_i     (arith),
    .right_res_o (right_res),
    .left_res_o  (left_res)
  );

  dsp_shift u_dsp_shift (
    .op_i        (op_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .right_res_i (right_res),
    .left_res_i  (left_res),
    .add_res_i   (add_res),
    .shift_op_o  (shift_op),
    .shamt_o     (shamt),
    .arith_o     (arith),
    .round_req_o (round_req),
    .round_op1_o (round_op1),
    .round_op2_o (round_op2),
    .wdat_o      (shift_wdat),
    .ov_o        (shift_ov)
  );

  //////////////////////////////////////////////////////////////////////
  // write-back
  //////////////////////////////////////////////////////////////////////
  dsp_wbck u_dsp_wbck (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .addsub_wdat_i (addsub_wdat),
    .shift_wdat_i  (shift_wdat),
    .addsub_ov_i   (addsub_ov),
    .shift_ov_i    (shift_ov),
    .in_valid_i    (in_valid_i),
    .out_ready_i   (out_ready_i),
    .ov_clr_i      (ov_clr_i),
    .wbck_wdat_o   (wbck_wdat_o),
    .wbck_ov_o     (wbck_ov_o),
    .ov_flag_o     (ov_flag_o)
  );

endmodule

/* rtl/dsp_wbck.sv */
`timescale 1ns/100ps

module dsp_wbck import dsp_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic [xlen-1:0] addsub_wdat_i,
  input  logic [xlen-1:0] shift_wdat_i,
  input  logic            addsub_ov_i,
  input  logic            shift_ov_i,
  input  logic            in_valid_i,
  input  logic            out_ready_i,
  input  logic            ov_clr_i,
  output logic [xlen-1:0] wbck_wdat_o,
  output logic            wbck_ov_o,
  output logic            ov_flag_o
);

  logic ov_lvl;
  logic accept;
  logic ov_flag_q;

  //////////////////////////////////////////////////////////////////////
  // write-back data and overflow pulse
  //////////////////////////////////////////////////////////////////////

  // each unit drives zero unless the op is its own
  assign wbck_wdat_o = addsub_wdat_i | shift_wdat_i;
  assign ov_lvl      = addsub_ov_i | shift_ov_i;

  // output valid follows input valid, so this is the output handshake
  assign accept    = in_valid_i & out_ready_i;
  assign wbck_ov_o = ov_lvl & accept;

  //////////////////////////////////////////////////////////////////////
  // sticky overflow flag
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ov_flag_q <= 1'b0;
    end else if (wbck_ov_o) begin
      // a new overflow beats a clear in the same cycle
      ov_flag_q <= 1'b1;
    end else if (ov_clr_i) begin
      ov_flag_q <= 1'b0;
    end
  end

  assign ov_flag_o = ov_flag_q;

endmodule

/* testbench/dsp_testdata.txt */
# op rs1 rs2 in_valid out_ready ov_clr exp_wdat exp_wbck_ov exp_ov_flag (all hex)
# exp_ov_flag is ov_flag_o just after the clock edge that ends the vector
f 12345678 9abcdef0 1 1 0 00000000 0 0
0 0001ffff 00010001 1 1 0 00020000 0 0
1 00000005 00010006 1 1 0 ffffffff 0 0
6 ff80017f 01800101 1 1 0 00000280 0 0
7 00108000 01200001 1 1 0 fff080ff 0 0
2 7fff8000 7fff8001 1 1 0 7fff8000 0 0
2 fffd0005 00000002 1 1 0 fffe0003 0 0
3 10002000 01000100 1 1 0 11002100 0 0
3 7fff0001 00010001 1 1 0 7fff0002 1 1
8 01020304 10203040 1 1 0 11223344 0 1
4 80007fff 0001ffff 1 1 1 80007fff 1 1
5 80000001 7fff0001 1 1 1 ffff0002 0 0
5 fff01234 00200001 1 1 0 ffff1235 1 1
f ffffffff ffffffff 1 1 1 00000000 0 0
8 7f80107f 01ff1000 1 1 0 7f80207f 1 1
9 80050a00 01070380 1 1 0 80fe077f 1 1
a 8000f0f0 00000004 1 1 1 08000f0f 0 0
b 8000f0f0 00000004 1 1 0 f800ff0f 0 0
b 8001ffff 000000f0 1 1 0 8001ffff 0 0
c 1234abcd 00000000 1 1 0 1234abcd 0 0
c 0003fffd 00000001 1 1 0 0002ffff 0 0
c 00ff7fff 00000004 1 1 0 00100800 0 0
c 7fff8000 00000001 1 1 0 4000c000 0 0
d 81234567 00000014 1 1 0 12305670 0 0
e 0012ffe0 00000003 1 1 0 0090ff00 0 0
3 7fff0000 00010000 1 0 0 7fff0000 0 0
e 40000010 00000002 0 1 0 7fff0040 0 0
e 40000010 00000002 1 1 0 7fff0040 1 1
e 00018001 00000001 1 0 0 00028000 0 1
e 00018001 00000001 1 1 0 00028000 1 1
0 7fff7fff 00010001 1 1 1 80008000 0 0
f 00000000 00000000 0 0 0 00000000 0 0

/* testbench/tb_dsp_unit.sv */
`timescale 1ns/100ps

module tb_dsp_unit import dsp_pkg::*; ();

  localparam int    clk_period    = 20;
  localparam int    reset_cycles  = 10;
  localparam int    drive_delay   = 1;
  localparam int    sample_lead   = 1;
  localparam int    margin_cycles = 20;
  localparam string data_path     = "testbench/dsp_testdata.txt";

  logic            clk;
  logic            rst_n_i;
  dsp_op_e         op_i;
  logic [xlen-1:0] rs1_i;
  logic [xlen-1:0] rs2_i;
  logic            in_valid_i;
  logic            in_ready_o;
  logic            out_valid_o;
  logic            out_ready_i;
  logic            ov_clr_i;
  logic [xlen-1:0] wbck_wdat_o;
  logic            wbck_ov_o;
  logic            ov_flag_o;

  // one entry per data file line
  logic [3:0]      vec_op[$];
  logic [xlen-1:0] vec_rs1[$];
  logic [xlen-1:0] vec_rs2[$];
  logic            vec_valid[$];
  logic            vec_ready[$];
  logic            vec_clr[$];
  logic [xlen-1:0] vec_wdat[$];
  logic            vec_ov[$];
  logic            vec_flag[$];

  int   mismatch_count = 0;
  int   other_count    = 0;
  int   check_count    = 0;
  logic vectors_loaded = 1'b0;

  dsp_unit i_dut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .op_i        (op_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .ov_clr_i    (ov_clr_i),
    .wbck_wdat_o (wbck_wdat_o),
    .wbck_ov_o   (wbck_ov_o),
    .ov_flag_o   (ov_flag_o)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////
  task automatic check_value(input string sig_name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, sig_name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          rc;
    int          line_no;
    string       line;
    logic [31:0] fld[9];
    line_no = 0;
    fd = $fopen(data_path, "r");
    if (fd == 0) begin
      $display("could not open the data file %s", data_path);
      other_count++;
      return;
    end
    rc = $fgets(line, fd);
    while (rc != 0) begin
      line_no++;
      // comment lines start with a hash
      if (line.len() >= 2 && line.getc(0) != "#") begin
        rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                     fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
        if (rc != 9) begin
          $display("line %0d of %s is malformed, it has %0d of 9 fields",
                   line_no, data_path, rc);
          other_count++;
        end else begin
          vec_op.push_back(fld[0][3:0]);
          vec_rs1.push_back(fld[1]);
          vec_rs2.push_back(fld[2]);
          vec_valid.push_back(fld[3][0]);
          vec_ready.push_back(fld[4][0]);
          vec_clr.push_back(fld[5][0]);
          vec_wdat.push_back(fld[6]);
          vec_ov.push_back(fld[7][0]);
          vec_flag.push_back(fld[8][0]);
        end
      end
      rc = $fgets(line, fd);
    end
    $fclose(fd);
    if (vec_op.size() == 0) begin
      $display("the data file %s holds no test vectors", data_path);
      other_count++;
    end
  endtask

  // drive at edge plus 1 ns, sample just before the next edge, flag just after it
  task automatic run_vector(input int idx);
    op_i        = dsp_op_e'(vec_op[idx]);
    rs1_i       = vec_rs1[idx];
    rs2_i       = vec_rs2[idx];
    in_valid_i  = vec_valid[idx];
    out_ready_i = vec_ready[idx];
    ov_clr_i    = vec_clr[idx];
    #(clk_period - drive_delay - sample_lead);
    check_value("wbck_wdat_o", wbck_wdat_o, vec_wdat[idx]);
    check_value("wbck_ov_o", 32'(wbck_ov_o), 32'(vec_ov[idx]));
    // handshake is a straight pass-through
    check_value("in_ready_o", 32'(in_ready_o), 32'(vec_ready[idx]));
    check_value("out_valid_o", 32'(out_valid_o), 32'(vec_valid[idx]));
    @(posedge clk);
    #drive_delay;
    check_value("ov_flag_o", 32'(ov_flag_o), 32'(vec_flag[idx]));
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    rst_n_i     = 1'b0;
    // a saturating accepted item during reset must not set the flag
    op_i        = op_kadd16;
    rs1_i       = 32'h7fff_7fff;
    rs2_i       = 32'h0001_0001;
    in_valid_i  = 1'b1;
    out_ready_i = 1'b1;
    ov_clr_i    = 1'b0;
    load_vectors();
    if (other_count == 0) begin
      vectors_loaded = 1'b1;
    end
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    rst_n_i = 1'b1;
    if (vectors_loaded) begin
      for (int i = 0; i < vec_op.size(); i++) begin
        run_vector(i);
      end
    end
    $display("summary: %0d vectors, %0d checks, %0d mismatches, %0d other errors",
             vec_op.size(), check_count, mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog sized from the vector count
  initial begin
    wait (vectors_loaded);
    #((vec_op.size() + reset_cycles + margin_cycles) * clk_period);
    $display("watchdog expired before all vectors were applied");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
